// ==== hdl/msr_config.svh ====
`ifndef MSR_CONFIG_SVH
`define MSR_CONFIG_SVH

// Datapath widths
`define MSR_DW          32
`define MSR_PSR_DW      10
`define MSR_TLB_AW      4

// Bank field sits in address bits 13..9
`define MSR_BANK_LSB    9
`define MSR_BANK_AW     5

// Bank codes
`define MSR_BANK_PS     5'd0
`define MSR_BANK_IMM    5'd1

// Register mode on, everything else off
`define MSR_PSR_RESET   10'h010

// Read-only identification registers
`define MSR_CPUID_VAL   32'h0032_0101
`define MSR_COREID_VAL  32'h0000_0003
`define MSR_IMMID_VAL   32'h0000_1004

`endif

// ==== hdl/msr_exec_stage.sv ====
`timescale 1ns/1ps
`include "msr_config.svh"

module msr_exec_stage
   import msr_pkg::*;
(
   input  logic               clk,
   input  logic               reset,
   input  msr_cmd_t           cmd,
   input  logic               cmd_valid,
   input  msr_rd_t            rd,
   input  logic               req,
   output msr_wr_t            wr,
   output logic               ack,
   output logic [`MSR_DW-1:0] rdata
);

   msr_addr_ps_t  ps;
   msr_addr_imm_t imm;
   logic bank_ps;
   logic bank_imm;
   logic tlbl_sel;
   logic tlbh_sel;
   logic is_wmsr;
   logic is_syscall;
   logic is_ret;
   logic is_setcc;
   logic [`MSR_DW-1:0] dout_ps;
   logic [`MSR_DW-1:0] dout_imm;
   logic [`MSR_DW-1:0] dout;

   // Operand word into PSR layout, reserved bits dropped
   function automatic psr_t word_to_psr(input logic [`MSR_DW-1:0] w);
      psr_t p;
      p        = psr_t'(w[`MSR_PSR_DW-1:0]);
      p.rsv_hi = '0;
      p.rsv_lo = '0;
      return p;
   endfunction

   assign ps  = cmd.addr.ps;
   assign imm = cmd.addr.imm;

   // Bank field is common to both views
   assign bank_ps  = (ps.bank == `MSR_BANK_PS);
   assign bank_imm = (ps.bank == `MSR_BANK_IMM);

   assign is_wmsr    = cmd_valid & (cmd.op == op_wmsr);
   assign is_syscall = cmd_valid & (cmd.op == op_syscall);
   assign is_ret     = cmd_valid & (cmd.op == op_ret);
   assign is_setcc   = cmd_valid & (cmd.op == op_setcc);

   // Processor-state read-out
   assign dout_ps =
      ({`MSR_DW{ps.psr_sel}}    & {{(`MSR_DW-`MSR_PSR_DW){1'b0}}, rd.psr}) |
      ({`MSR_DW{ps.cpuid_sel}}  & `MSR_CPUID_VAL) |
      ({`MSR_DW{ps.epsr_sel}}   & {{(`MSR_DW-`MSR_PSR_DW){1'b0}}, rd.epsr}) |
      ({`MSR_DW{ps.epc_sel}}    & rd.epc) |
      ({`MSR_DW{ps.elsa_sel}}   & rd.elsa) |
      ({`MSR_DW{ps.coreid_sel}} & `MSR_COREID_VAL);

   // IMMID when no TLB word is selected
   assign tlbl_sel = imm.tlbsel & ~imm.tlbh_sel;
   assign tlbh_sel = imm.tlbsel & imm.tlbh_sel;
   assign dout_imm =
      ({`MSR_DW{~imm.tlbsel}} & `MSR_IMMID_VAL) |
      ({`MSR_DW{tlbl_sel}}    & rd.tlbl) |
      ({`MSR_DW{tlbh_sel}}    & rd.tlbh);

   // Other banks read as zero
   assign dout = ({`MSR_DW{bank_ps}} & dout_ps) | ({`MSR_DW{bank_imm}} & dout_imm);

   // Write side, built from the command only
   always_comb begin
      wr.psr_we      = is_wmsr & bank_ps & ps.psr_sel;
      wr.cc_we       = is_setcc;
      wr.epsr_we     = (is_wmsr & bank_ps & ps.epsr_sel) | is_syscall;
      wr.epc_we      = (is_wmsr & bank_ps & ps.epc_sel) | is_syscall;
      wr.elsa_we     = is_wmsr & bank_ps & ps.elsa_sel;
      wr.tlbl_we     = is_wmsr & bank_imm & tlbl_sel;
      wr.tlbh_we     = is_wmsr & bank_imm & tlbh_sel;
      wr.syscall_ent = is_syscall;
      wr.ret         = is_ret;
      // New cc rides in bit 0 for both wmsr and setcc
      wr.psr_nxt     = word_to_psr(cmd.wdata);
      wr.epsr_nxt    = word_to_psr(cmd.wdata);
      wr.epc_nxt     = is_syscall ? cmd.linkaddr : cmd.wdata;
      wr.data_nxt    = cmd.wdata;
      wr.tlb_idx     = imm.idx;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         ack <= 1'b0;
      end else if (cmd_valid) begin
         ack <= 1'b1;
      end else if (!req) begin
         ack <= 1'b0;
      end
   end

   // Old value of the addressed register
   always_ff @(posedge clk) begin
      if (cmd_valid) begin
         rdata <= dout;
      end
   end

endmodule

// ==== hdl/msr_pkg.sv ====
`include "msr_config.svh"

package msr_pkg;

   typedef enum logic [2:0] {
      op_rmsr,
      op_wmsr,
      op_syscall,
      op_ret,
      op_setcc
   } msr_op_e;

   // Processor status word, reserved bits kept at zero
   typedef struct packed {
      logic [1:0] rsv_hi;
      logic       dmme;
      logic       imme;
      logic       ire;
      logic       rm;
      logic [2:0] rsv_lo;
      logic       cc;
   } psr_t;

   // Processor-state bank view, one-hot register selects
   typedef struct packed {
      logic [`MSR_DW-`MSR_BANK_LSB-`MSR_BANK_AW-1:0] upper;
      logic [`MSR_BANK_AW-1:0]                      bank;
      logic [`MSR_BANK_LSB-7:0]                     rsv;
      logic                                         coreid_sel;
      logic                                         elsa_sel;
      logic                                         epc_sel;
      logic                                         epsr_sel;
      logic                                         cpuid_sel;
      logic                                         psr_sel;
   } msr_addr_ps_t;

   // Instruction-MMU bank view
   typedef struct packed {
      logic [`MSR_DW-`MSR_BANK_LSB-`MSR_BANK_AW-1:0] upper;
      logic [`MSR_BANK_AW-1:0]                      bank;
      logic                                         tlbsel;
      logic                                         tlbh_sel;
      logic [`MSR_BANK_LSB-3-`MSR_TLB_AW:0]         rsv;
      logic [`MSR_TLB_AW-1:0]                       idx;
   } msr_addr_imm_t;

   typedef union packed {
      msr_addr_ps_t      ps;
      msr_addr_imm_t     imm;
      logic [`MSR_DW-1:0] raw;
   } msr_addr_u;

   typedef struct packed {
      msr_op_e            op;
      msr_addr_u          addr;
      logic [`MSR_DW-1:0] wdata;
      logic [`MSR_DW-1:0] linkaddr;
   } msr_cmd_t;

   typedef struct packed {
      logic                   psr_we;
      logic                   cc_we;
      logic                   epsr_we;
      logic                   epc_we;
      logic                   elsa_we;
      logic                   tlbl_we;
      logic                   tlbh_we;
      logic                   syscall_ent;
      logic                   ret;
      psr_t                   psr_nxt;
      psr_t                   epsr_nxt;
      logic [`MSR_DW-1:0]     epc_nxt;
      logic [`MSR_DW-1:0]     data_nxt;
      logic [`MSR_TLB_AW-1:0] tlb_idx;
   } msr_wr_t;

   typedef struct packed {
      psr_t               psr;
      psr_t               epsr;
      logic [`MSR_DW-1:0] epc;
      logic [`MSR_DW-1:0] elsa;
      logic [`MSR_DW-1:0] tlbl;
      logic [`MSR_DW-1:0] tlbh;
   } msr_rd_t;

endpackage

// ==== hdl/msr_regfile.sv ====
`timescale 1ns/1ps
`include "msr_config.svh"

module msr_regfile
   import msr_pkg::*;
(
   input  logic    clk,
   input  logic    reset,
   input  msr_wr_t wr,
   output msr_rd_t rd
);

   localparam int TLB_DEPTH = 1 << `MSR_TLB_AW;

   psr_t               psr;
   psr_t               epsr;
   psr_t               psr_sys;
   logic [`MSR_DW-1:0] epc;
   logic [`MSR_DW-1:0] elsa;
   logic [`MSR_DW-1:0] tlbl_mem [TLB_DEPTH];
   logic [`MSR_DW-1:0] tlbh_mem [TLB_DEPTH];

   // PSR on system-call entry
   always_comb begin
      psr_sys      = psr;
      psr_sys.ire  = 1'b0;
      psr_sys.imme = 1'b0;
      psr_sys.dmme = 1'b0;
      psr_sys.rm   = 1'b1;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         psr  <= psr_t'(`MSR_PSR_RESET);
         epsr <= '0;
         epc  <= '0;
         elsa <= '0;
      end else begin
         if (wr.ret) begin
            psr <= epsr;
         end else if (wr.syscall_ent) begin
            psr <= psr_sys;
         end else if (wr.psr_we) begin
            psr <= wr.psr_nxt;
         end else if (wr.cc_we) begin
            psr.cc <= wr.psr_nxt.cc;
         end

         // Syscall saves the PSR as it was before entry
         if (wr.epsr_we) begin
            epsr <= wr.syscall_ent ? psr : wr.epsr_nxt;
         end
         if (wr.epc_we) begin
            epc <= wr.epc_nxt;
         end
         if (wr.elsa_we) begin
            elsa <= wr.data_nxt;
         end
      end
   end

   // TLB word arrays
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < TLB_DEPTH; i++) begin
            tlbl_mem[i] <= '0;
            tlbh_mem[i] <= '0;
         end
      end else begin
         if (wr.tlbl_we) begin
            tlbl_mem[wr.tlb_idx] <= wr.data_nxt;
         end
         if (wr.tlbh_we) begin
            tlbh_mem[wr.tlb_idx] <= wr.data_nxt;
         end
      end
   end

   always_comb begin
      rd.psr  = psr;
      rd.epsr = epsr;
      rd.epc  = epc;
      rd.elsa = elsa;
      rd.tlbl = tlbl_mem[wr.tlb_idx];
      rd.tlbh = tlbh_mem[wr.tlb_idx];
   end

endmodule

// ==== hdl/msr_req_stage.sv ====
`timescale 1ns/1ps
`include "msr_config.svh"

module msr_req_stage
   import msr_pkg::*;
(
   input  logic               clk,
   input  logic               reset,
   input  logic               req,
   input  msr_op_e            cmd_op,
   input  logic [`MSR_DW-1:0] operand_1,
   input  logic [`MSR_DW-1:0] operand_2,
   input  logic [`MSR_DW-1:0] operand_3,
   input  logic [`MSR_DW-1:0] linkaddr,
   input  logic               ack,
   output msr_cmd_t           cmd,
   output logic               cmd_valid
);

   logic busy;
   logic new_req;
   logic [`MSR_DW-1:0] msr_addr;

   // A fresh request only once the previous handshake has fully closed
   assign new_req = req & ~busy & ~ack;

   assign msr_addr = operand_1 + operand_2;

   always_ff @(posedge clk) begin
      if (reset) begin
         busy      <= 1'b0;
         cmd_valid <= 1'b0;
      end else begin
         cmd_valid <= new_req;
         if (new_req) begin
            busy <= 1'b1;
         end else if (!req) begin
            // Held high req must not start a second command
            busy <= 1'b0;
         end
      end
   end

   // Command payload
   always_ff @(posedge clk) begin
      if (new_req) begin
         cmd.op       <= cmd_op;
         cmd.addr.raw <= msr_addr;
         cmd.wdata    <= operand_3;
         cmd.linkaddr <= linkaddr;
      end
   end

endmodule

// ==== hdl/msr_unit_top.sv ====
`timescale 1ns/1ps
`include "msr_config.svh"

module msr_unit_top
   import msr_pkg::*;
(
   input  logic               clk,
   input  logic               reset,
   input  logic               req,
   output logic               ack,
   input  msr_op_e            cmd_op,
   input  logic [`MSR_DW-1:0] operand_1,
   input  logic [`MSR_DW-1:0] operand_2,
   input  logic [`MSR_DW-1:0] operand_3,
   input  logic [`MSR_DW-1:0] linkaddr,
   output logic [`MSR_DW-1:0] rdata
);

   msr_cmd_t cmd;
   logic     cmd_valid;
   msr_wr_t  wr;
   msr_rd_t  rd;

   msr_req_stage u_msr_req_stage (
      .clk       (clk),
      .reset     (reset),
      .req       (req),
      .cmd_op    (cmd_op),
      .operand_1 (operand_1),
      .operand_2 (operand_2),
      .operand_3 (operand_3),
      .linkaddr  (linkaddr),
      .ack       (ack),
      .cmd       (cmd),
      .cmd_valid (cmd_valid)
   );

   msr_exec_stage u_msr_exec_stage (
      .clk       (clk),
      .reset     (reset),
      .cmd       (cmd),
      .cmd_valid (cmd_valid),
      .rd        (rd),
      .req       (req),
      .wr        (wr),
      .ack       (ack),
      .rdata     (rdata)
   );

   msr_regfile u_msr_regfile (
      .clk   (clk),
      .reset (reset),
      .wr    (wr),
      .rd    (rd)
   );

endmodule

// ==== msr_unit.f ====
+incdir+hdl
hdl/msr_pkg.sv
hdl/msr_req_stage.sv
hdl/msr_exec_stage.sv
hdl/msr_regfile.sv
hdl/msr_unit_top.sv
tb/msr_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f msr_unit.f --top-module msr_unit_tb -o msr_unit_sim
sim_output="$(./obj_dir/msr_unit_sim)"
echo "$sim_output"

if echo "$sim_output" | grep -q "Regression passed"; then
   exit 0
else
   exit 1
fi

// ==== tb/msr_unit_tb.sv ====
`timescale 1ns/1ps
`include "msr_config.svh"

module msr_unit_tb
   import msr_pkg::*;
;

   // About 85 commands at 4 to 8 cycles each plus reset, with margin
   localparam int TIMEOUT_CYCLES = 2000;
   localparam int ACK_WAIT_LIMIT = 20;
   localparam logic [31:0] PSR_WR_MASK = 32'h0000_00f1;
   localparam int SEL_PSR = 0;
   localparam int SEL_CPUID = 1;
   localparam int SEL_EPSR = 2;
   localparam int SEL_EPC = 3;
   localparam int SEL_ELSA = 4;
   localparam int SEL_COREID = 5;

   logic        clk = 1'b0;
   logic        reset;
   logic        req;
   logic        ack;
   msr_op_e     cmd_op;
   logic [31:0] operand_1;
   logic [31:0] operand_2;
   logic [31:0] operand_3;
   logic [31:0] linkaddr;
   logic [31:0] rdata;

   logic [31:0] lfsr = 32'd90969;
   int          cycle_count = 0;
   int          check_count = 0;
   int          error_count = 0;

   // Reference copies of the stored registers
   logic [31:0] model_psr;
   logic [31:0] model_epsr;
   logic [31:0] model_epc;
   logic [31:0] model_elsa;
   logic [31:0] model_tlbl [16];
   logic [31:0] model_tlbh [16];

   msr_unit_top u_msr_unit_top (
      .clk       (clk),
      .reset     (reset),
      .req       (req),
      .ack       (ack),
      .cmd_op    (cmd_op),
      .operand_1 (operand_1),
      .operand_2 (operand_2),
      .operand_3 (operand_3),
      .linkaddr  (linkaddr),
      .rdata     (rdata)
   );

   always #10 clk = ~clk;

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("run stopped after %0d cycles without finishing", cycle_count);
         $display("checks %0d, errors %0d", check_count, error_count + 1);
         $display("Regression failed");
         $finish;
      end
   end

   // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
   function automatic logic [31:0] next_random(input int n);
      logic [31:0] value;
      logic        fb;
      int          i;
      value = '0;
      for (i = 0; i < n; i++) begin
         fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         value = {value[30:0], fb};
      end
      return value;
   endfunction

   function automatic logic [31:0] ps_addr(input int sel);
      return {18'b0, `MSR_BANK_PS, 9'b0} | (32'h1 << sel);
   endfunction

   function automatic logic [31:0] tlb_addr(input logic high, input logic [3:0] idx);
      return {18'b0, `MSR_BANK_IMM, 1'b1, high, 3'b0, idx};
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      check_count++;
      assert (actual === expected) else begin
         $display("error %s expected %h actual %h", name, expected, actual);
         error_count++;
      end
   endtask

   // Four-phase handshake, address split randomly over both operands
   task automatic issue_cmd(input msr_op_e op, input logic [31:0] addr,
                            input logic [31:0] data, input logic [31:0] link,
                            input int hold, output logic [31:0] result);
      logic [31:0] split;
      int          waited;
      int          i;
      split = next_random(32);
      cmd_op = op;
      operand_1 = split;
      operand_2 = addr - split;
      operand_3 = data;
      linkaddr = link;
      req = 1'b1;
      waited = 0;
      while (!ack && waited < ACK_WAIT_LIMIT) begin
         @(posedge clk);
         #2;
         waited++;
      end
      assert (ack) else begin
         $display("no ack within %0d cycles for %s", ACK_WAIT_LIMIT, op.name());
         error_count++;
      end
      result = rdata;
      // Holding req keeps ack and rdata steady
      for (i = 0; i < hold; i++) begin
         @(posedge clk);
         #2;
         check_value("ack", 32'h1, {31'b0, ack});
         check_value("rdata", result, rdata);
      end
      req = 1'b0;
      waited = 0;
      while (ack && waited < ACK_WAIT_LIMIT) begin
         @(posedge clk);
         #2;
         waited++;
      end
      assert (!ack) else begin
         $display("ack did not fall after req dropped for %s", op.name());
         error_count++;
      end
   endtask

   task automatic access(input msr_op_e op, input logic [31:0] addr, input logic [31:0] data,
                         input logic [31:0] expected, input string name);
      logic [31:0] result;
      issue_cmd(op, addr, data, 32'h0, 0, result);
      check_value(name, expected, result);
   endtask

   task automatic test_reset_handshake();
      logic [31:0] result;
      logic [31:0] data;
      check_value("ack", 32'h0, {31'b0, ack});
      access(op_rmsr, ps_addr(SEL_PSR), 32'h0, 32'h010, "rdata psr");
      access(op_rmsr, ps_addr(SEL_CPUID), 32'h0, `MSR_CPUID_VAL, "rdata cpuid");
      access(op_rmsr, ps_addr(SEL_COREID), 32'h0, `MSR_COREID_VAL, "rdata coreid");
      access(op_rmsr, {18'b0, `MSR_BANK_IMM, 9'b0}, 32'h0, `MSR_IMMID_VAL, "rdata immid");
      // A second capture of a held write would show the new value in rdata
      data = next_random(32);
      issue_cmd(op_wmsr, ps_addr(SEL_ELSA), data, 32'h0, 4, result);
      check_value("rdata elsa held", model_elsa, result);
      model_elsa = data;
   endtask

   task automatic test_ps_writes();
      logic [31:0] data;
      data = next_random(32);
      access(op_wmsr, ps_addr(SEL_PSR), data, model_psr, "rdata psr old");
      model_psr = data & PSR_WR_MASK;
      access(op_rmsr, ps_addr(SEL_PSR), 32'h0, model_psr, "rdata psr");
      data = next_random(32);
      access(op_wmsr, ps_addr(SEL_EPSR), data, model_epsr, "rdata epsr old");
      model_epsr = data & PSR_WR_MASK;
      access(op_rmsr, ps_addr(SEL_EPSR), 32'h0, model_epsr, "rdata epsr");
      data = next_random(32);
      access(op_wmsr, ps_addr(SEL_EPC), data, model_epc, "rdata epc old");
      model_epc = data;
      access(op_rmsr, ps_addr(SEL_EPC), 32'h0, model_epc, "rdata epc");
      data = next_random(32);
      access(op_wmsr, ps_addr(SEL_ELSA), data, model_elsa, "rdata elsa old");
      model_elsa = data;
      access(op_rmsr, ps_addr(SEL_ELSA), 32'h0, model_elsa, "rdata elsa");
   endtask

   task automatic test_tlb_writes();
      logic [3:0]  idx;
      logic [31:0] data;
      repeat (4) begin
         idx = 4'(next_random(4));
         data = next_random(32);
         access(op_wmsr, tlb_addr(1'b0, idx), data, model_tlbl[idx], "rdata tlbl old");
         model_tlbl[idx] = data;
         access(op_rmsr, tlb_addr(1'b1, idx), 32'h0, model_tlbh[idx], "rdata tlbh kept");
         data = next_random(32);
         access(op_wmsr, tlb_addr(1'b1, idx), data, model_tlbh[idx], "rdata tlbh old");
         model_tlbh[idx] = data;
         access(op_rmsr, tlb_addr(1'b0, idx), 32'h0, model_tlbl[idx], "rdata tlbl");
         access(op_rmsr, tlb_addr(1'b1, idx), 32'h0, model_tlbh[idx], "rdata tlbh");
      end
   endtask

   task automatic test_syscall_ret();
      logic [31:0] link;
      logic [31:0] result;
      access(op_wmsr, ps_addr(SEL_PSR), 32'hffff_ffff, model_psr, "rdata psr old");
      model_psr = PSR_WR_MASK;
      link = next_random(32);
      issue_cmd(op_syscall, 32'h0, 32'h0, link, 0, result);
      check_value("rdata syscall", 32'h0, result);
      model_epsr = model_psr;
      model_epc = link;
      // rm set, ire imme dmme cleared
      model_psr = (model_psr & ~32'h0e0) | 32'h010;
      access(op_rmsr, ps_addr(SEL_EPSR), 32'h0, model_epsr, "rdata epsr");
      access(op_rmsr, ps_addr(SEL_EPC), 32'h0, model_epc, "rdata epc");
      access(op_rmsr, ps_addr(SEL_PSR), 32'h0, model_psr, "rdata psr");
      access(op_ret, 32'h0, 32'h0, 32'h0, "rdata ret");
      model_psr = model_epsr;
      access(op_rmsr, ps_addr(SEL_PSR), 32'h0, model_psr, "rdata psr");
   endtask

   task automatic test_setcc_unknown_bank();
      logic [31:0] unknown;
      logic [31:0] data;
      int          i;
      data = next_random(31) << 1;
      access(op_setcc, 32'h0, data, 32'h0, "rdata setcc");
      model_psr[0] = 1'b0;
      access(op_rmsr, ps_addr(SEL_PSR), 32'h0, model_psr, "rdata psr cc");
      data = (next_random(31) << 1) | 32'h1;
      access(op_setcc, 32'h0, data, 32'h0, "rdata setcc");
      model_psr[0] = 1'b1;
      access(op_rmsr, ps_addr(SEL_PSR), 32'h0, model_psr, "rdata psr cc");
      unknown = {18'b0, 5'd5, 9'h1ff};
      access(op_rmsr, unknown, 32'h0, 32'h0, "rdata unknown bank");
      access(op_wmsr, unknown, next_random(32), 32'h0, "rdata unknown bank");
      access(op_rmsr, ps_addr(SEL_PSR), 32'h0, model_psr, "rdata psr");
      access(op_rmsr, ps_addr(SEL_EPSR), 32'h0, model_epsr, "rdata epsr");
      access(op_rmsr, ps_addr(SEL_EPC), 32'h0, model_epc, "rdata epc");
      access(op_rmsr, ps_addr(SEL_ELSA), 32'h0, model_elsa, "rdata elsa");
      for (i = 0; i < 16; i++) begin
         access(op_rmsr, tlb_addr(1'b0, 4'(i)), 32'h0, model_tlbl[i], "rdata tlbl");
         access(op_rmsr, tlb_addr(1'b1, 4'(i)), 32'h0, model_tlbh[i], "rdata tlbh");
      end
   endtask

   initial begin
      reset = 1'b1;
      req = 1'b0;
      cmd_op = op_rmsr;
      operand_1 = '0;
      operand_2 = '0;
      operand_3 = '0;
      linkaddr = '0;
      model_psr = {22'b0, `MSR_PSR_RESET};
      model_epsr = '0;
      model_epc = '0;
      model_elsa = '0;
      for (int i = 0; i < 16; i++) begin
         model_tlbl[i] = '0;
         model_tlbh[i] = '0;
      end
      repeat (16) @(posedge clk);
      #2;
      reset = 1'b0;

      test_reset_handshake();
      test_ps_writes();
      test_tlb_writes();
      test_syscall_ret();
      test_setcc_unknown_bank();

      $display("checks %0d, errors %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule
